//--- run.sh
#!/bin/sh
# compile and run the rvCore testbench; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
    --top-module tbRvCore -Mdir obj_dir &&
./obj_dir/VtbRvCore || exit 1

//--- sim/tbProgram.svh
// test program, instruction encoders, reference ALU and stall LFSR; included inside the testbench
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef enum int {
    opAdd, opSub, opSlt, opXor, opOr, opAnd, opSll, opSrl, opSra
} aluOp_t;

logic [31:0] imem [0:63];
int          progLen;
logic [31:0] refRegs [0:31];
logic [4:0]  expRd[$];
logic [31:0] expData[$];

function automatic logic [2:0] funct3Of(input aluOp_t op);
    case (op)
        opSll:        return 3'b001;
        opSlt:        return 3'b010;
        opXor:        return 3'b100;
        opSrl, opSra: return 3'b101;
        opOr:         return 3'b110;
        opAnd:        return 3'b111;
        default:      return 3'b000;
    endcase
endfunction

// RV32I result of one operation
function automatic logic [31:0] refAlu(input aluOp_t op, input logic [31:0] a,
                                       input logic [31:0] b);
    case (op)
        opSub:   return a - b;
        opSlt:   return {31'd0, ($signed(a) < $signed(b))};
        opXor:   return a ^ b;
        opOr:    return a | b;
        opAnd:   return a & b;
        opSll:   return a << b[4:0];
        opSrl:   return a >> b[4:0];
        opSra:   return $signed(a) >>> b[4:0];
        default: return a + b;
    endcase
endfunction

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// memory holds words byte-reversed; writes to x0 leave no trace
task automatic storeInst(input rvPkg::instWord_t w, input logic valid,
                         input logic [31:0] result);
    imem[progLen[5:0]] = {w[7:0], w[15:8], w[23:16], w[31:24]};
    progLen++;
    if (valid && w.rType.rd != 5'd0) begin
        refRegs[w.rType.rd] = result;
        expRd.push_back(w.rType.rd);
        expData.push_back(result);
    end
endtask

task automatic addRegInst(input aluOp_t op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
    rvPkg::instWord_t w;
    w.rType.funct7 = (op == opSub || op == opSra) ? 7'b0100000 : 7'b0000000;
    w.rType.rs2    = rs2;
    w.rType.rs1    = rs1;
    w.rType.funct3 = funct3Of(op);
    w.rType.rd     = rd;
    w.rType.opcode = 7'b0110011;
    storeInst(w, 1'b1, refAlu(op, refRegs[rs1], refRegs[rs2]));
endtask

// shifts take the shift amount in imm[4:0]
task automatic addImmInst(input aluOp_t op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
    rvPkg::instWord_t w;
    w.iType.imm12  = (op == opSra) ? {7'b0100000, imm[4:0]} : imm;
    w.iType.rs1    = rs1;
    w.iType.funct3 = funct3Of(op);
    w.iType.rd     = rd;
    w.iType.opcode = 7'b0010011;
    storeInst(w, 1'b1, refAlu(op, refRegs[rs1], {{20{w.iType.imm12[11]}}, w.iType.imm12}));
endtask

task automatic buildProgram();
    for (int i = 0; i < 32; i++) begin
        refRegs[i] = '0;
    end
    progLen = 0;
    addImmInst(opAdd, 5'd1, 5'd0, 12'h005);
    addImmInst(opAdd, 5'd2, 5'd0, 12'hffd);
    addRegInst(opAdd, 5'd3, 5'd1, 5'd2);
    addRegInst(opSub, 5'd4, 5'd3, 5'd1);
    addRegInst(opSlt, 5'd5, 5'd4, 5'd1);
    addRegInst(opSlt, 5'd6, 5'd1, 5'd4);
    addImmInst(opAdd, 5'd0, 5'd1, 12'h007);
    addRegInst(opAdd, 5'd7, 5'd0, 5'd1);
    addRegInst(opXor, 5'd8, 5'd7, 5'd2);
    addRegInst(opOr,  5'd9, 5'd8, 5'd1);
    addRegInst(opAnd, 5'd10, 5'd9, 5'd3);
    // LUI x11, not supported
    storeInst(32'h1234_55b7, 1'b0, '0);
    addRegInst(opSll, 5'd11, 5'd1, 5'd3);
    addRegInst(opSra, 5'd12, 5'd2, 5'd3);
    addRegInst(opSrl, 5'd13, 5'd2, 5'd3);
    addImmInst(opSlt, 5'd14, 5'd2, 12'hffe);
    addImmInst(opXor, 5'd15, 5'd14, 12'hfff);
    addImmInst(opOr,  5'd16, 5'd15, 12'h0f0);
    // LW x17, 0(x1), not supported
    storeInst(32'h0000_a883, 1'b0, '0);
    addImmInst(opAnd, 5'd17, 5'd16, 12'h7f0);
    addImmInst(opSll, 5'd18, 5'd17, 12'h004);
    addImmInst(opSrl, 5'd19, 5'd2, 12'h01c);
    addImmInst(opSra, 5'd20, 5'd4, 12'h001);
    addRegInst(opAdd, 5'd21, 5'd20, 5'd0);
    addImmInst(opAdd, 5'd1, 5'd1, 12'hfff);
endtask

`endif

//--- sim/tbRvCore.sv
// testbench for rvCore: instruction memory, random stalls and a reference trace of results
`default_nettype none

`include "rvConsts.svh"

module tbRvCore;
    timeunit 1ns;
    timeprecision 100ps;

    logic                  clk;
    logic                  rst_n;
    logic                  icStall = 1'b0;
    logic [`RV_XLEN-1:0]   icRdata = '0;
    logic [`RV_PC_W-1:0]   icAddr;
    logic                  wbValid;
    logic [`RV_REG_AW-1:0] wbRd;
    logic [`RV_XLEN-1:0]   wbData;

    // one-cycle history for the reset and stall checks
    logic                  rstPrev = 1'b0;
    logic [`RV_PC_W-1:0]   addrPrev = '0;
    logic [15:0]           lfsrState = 16'd38;
    int                    cycles = 0;
    int                    pulseCount = 0;
    logic                  issueSeen = 1'b0;
    int                    nonStallCount = 0;

    `include "tbProgram.svh"

    rvCore u_dut (
        .clk(clk), .rst_n(rst_n), .icAddr(icAddr), .icRdata(icRdata), .icStall(icStall),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        buildProgram();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        while (pulseCount < expRd.size()) @(posedge clk);
        // room for a late or duplicated result
        repeat (10) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

    // ============================================================
    // synchronous instruction memory and stall source
    // ============================================================

    always @(posedge clk) begin
        icRdata <= (int'(icAddr) < progLen) ? imem[icAddr[5:0]] : '0;
    end

    // two bits per cycle, so a stall about one cycle in four
    always @(posedge clk) begin : stallGen
        logic [15:0] stepOne;
        logic [15:0] stepTwo;
        stepOne = lfsrNext(lfsrState);
        stepTwo = lfsrNext(stepOne);
        lfsrState <= stepTwo;
        // first result is timed without stalls
        icStall <= rst_n && (pulseCount != 0) && stepOne[0] && stepTwo[0];
    end

    always @(posedge clk) begin
        rstPrev  <= rst_n;
        addrPrev <= icAddr;
        cycles   <= cycles + 1;
        if (cycles >= 8 * progLen + 40) begin
            failRun($sformatf("timeout after %0d cycles with %0d of %0d results seen",
                              cycles, pulseCount, expRd.size()));
        end
    end

    // ============================================================
    // checks
    // ============================================================

    always @(posedge clk) begin
        if (rst_n && !issueSeen && !icStall && icAddr == '0) begin
            issueSeen     <= 1'b1;
            nonStallCount <= 0;
        end else if (issueSeen && !icStall) begin
            nonStallCount <= nonStallCount + 1;
        end
        if (rst_n && wbValid) begin
            assert (pulseCount != 0 || nonStallCount == 3) else failRun($sformatf(
                "error at %0d ns: wbValid in non-stall cycle %0d after address 0, expected 4",
                $time, nonStallCount + 1));
            assert (pulseCount < expRd.size())
                else failRun("a result retired after the last expected one");
            assert (wbRd == expRd[pulseCount]) else failRun($sformatf(
                "error at %0d ns: wbRd is %0d, expected %0d", $time, wbRd, expRd[pulseCount]));
            assert (wbData == expData[pulseCount]) else failRun($sformatf(
                "error at %0d ns: wbData is 0x%08h, expected 0x%08h",
                $time, wbData, expData[pulseCount]));
            pulseCount <= pulseCount + 1;
        end
    end

    resetQuiet: assert property (@(posedge clk)
        (cycles != 0) && (!rst_n || !rstPrev) |-> !wbValid && (icAddr == '0)
    ) else failRun($sformatf("error at %0d ns: wbValid %0b and icAddr %0d, expected 0 and 0",
                             $time, $sampled(wbValid), $sampled(icAddr)));

    stallNoRetire: assert property (@(posedge clk) disable iff (!rst_n)
        icStall |-> !wbValid
    ) else failRun($sformatf("error at %0d ns: wbValid is 1 during a stall, expected 0", $time));

    stallAddrHeld: assert property (@(posedge clk) disable iff (!rst_n)
        icStall |-> icAddr == addrPrev
    ) else failRun($sformatf("error at %0d ns: icAddr is %0d during a stall, expected %0d",
                             $time, $sampled(icAddr), $sampled(addrPrev)));

endmodule

`default_nettype wire

//--- src/executeStage.sv
// execute stage: operand forwarding, ALU and the execute/writeback register feeding the trace
`default_nettype none

`include "rvConsts.svh"

module executeStage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     icStall,
    input  wire                     exRegWrite,
    input  wire                     exUseImm,
    input  wire  [3:0]              exAluCtrl,
    input  wire  [`RV_XLEN-1:0]     exImm,
    input  wire  [`RV_XLEN-1:0]     exOpA,
    input  wire  [`RV_XLEN-1:0]     exOpB,
    input  wire  [`RV_REG_AW-1:0]   exRd,
    input  wire  [`RV_REG_AW-1:0]   exRs1,
    input  wire  [`RV_REG_AW-1:0]   exRs2,
    output logic                    wbValid,
    output logic [`RV_REG_AW-1:0]   wbRd,
    output logic [`RV_XLEN-1:0]     wbData
);

    logic                wbWrReg;
    logic                fwdA;
    logic                fwdB;
    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] regB;
    logic [`RV_XLEN-1:0] opB;
    logic [`RV_XLEN:0]   diff;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] aluOut;

    // ============================================================
    // forwarding from the writeback register
    // ============================================================

    assign fwdA = wbWrReg && (wbRd != '0) && (wbRd == exRs1);
    assign fwdB = wbWrReg && (wbRd != '0) && (wbRd == exRs2);

    assign opA  = fwdA ? wbData : exOpA;
    assign regB = fwdB ? wbData : exOpB;
    assign opB  = exUseImm ? exImm : regB;

    // ============================================================
    // ALU
    // ============================================================

    // sign-extended so bit 32 is the signed less-than
    assign diff  = {opA[`RV_XLEN-1], opA} - {opB[`RV_XLEN-1], opB};
    assign shamt = opB[4:0];

    always_comb begin
        case (exAluCtrl)
            `RV_ALU_ADD: aluOut = opA + opB;
            `RV_ALU_SUB: aluOut = diff[`RV_XLEN-1:0];
            `RV_ALU_SLT: aluOut = {{(`RV_XLEN - 1){1'b0}}, diff[`RV_XLEN]};
            `RV_ALU_XOR: aluOut = opA ^ opB;
            `RV_ALU_OR:  aluOut = opA | opB;
            `RV_ALU_AND: aluOut = opA & opB;
            `RV_ALU_SLL: aluOut = opA << shamt;
            `RV_ALU_SRL: aluOut = opA >> shamt;
            `RV_ALU_SRA: aluOut = $signed(opA) >>> shamt;
            default:     aluOut = '0;
        endcase
    end

    // ============================================================
    // execute/writeback register
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbWrReg <= 1'b0;
            wbRd    <= '0;
        end else if (!icStall) begin
            wbWrReg <= exRegWrite;
            wbRd    <= exRd;
        end
    end

    always_ff @(posedge clk) begin
        if (!icStall) begin
            wbData <= aluOut;
        end
    end

    // held result retires once, on the first free cycle
    assign wbValid = wbWrReg && !icStall;

    // decoder must turn every unknown code into a bubble
    aluCodeKnown: assert property (
        @(posedge clk) disable iff (!rst_n)
        exRegWrite |-> exAluCtrl inside {`RV_ALU_ADD, `RV_ALU_SUB, `RV_ALU_SLT,
                                         `RV_ALU_XOR, `RV_ALU_OR,  `RV_ALU_AND,
                                         `RV_ALU_SLL, `RV_ALU_SRL, `RV_ALU_SRA}
    ) else $error("write enabled with unknown ALU code %b", exAluCtrl);

endmodule

`default_nettype wire

//--- src/fetchUnit.sv
// fetch stage: PC, instruction-memory address, byte reversal and the fetch/decode register
`default_nettype none

`include "rvConsts.svh"

module fetchUnit (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      icStall,
    input  wire  [`RV_XLEN-1:0]      icRdata,
    output logic [`RV_PC_W-1:0]      icAddr,
    output rvPkg::instWord_t         ifInst
);

    logic [`RV_PC_W-1:0] pc;
    // address whose data sits on icRdata this cycle
    logic [`RV_PC_W-1:0] lastAddr;
    logic                fetchValid;
    logic [`RV_XLEN-1:0] swapped;

    // memory word is stored byte-reversed
    assign swapped = {icRdata[7:0], icRdata[15:8], icRdata[23:16], icRdata[31:24]};

    // re-issue the pending address while frozen
    assign icAddr = icStall ? lastAddr : pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= '0;
            lastAddr   <= '0;
            fetchValid <= 1'b0;
            ifInst     <= `RV_NOP;
        end else if (!icStall) begin
            pc         <= pc + `RV_PC_STEP;
            lastAddr   <= pc;
            fetchValid <= 1'b1;
            // nothing was requested before the first edge
            if (fetchValid) begin
                ifInst <= swapped;
            end else begin
                ifInst <= `RV_NOP;
            end
        end
    end

    // ============================================================
    // checks
    // ============================================================

    // memory must keep seeing the same address through a freeze
    icAddrHeld: assert property (
        @(posedge clk) disable iff (!rst_n)
        icStall |-> $stable(icAddr)
    ) else $error("icAddr moved during a stall");

endmodule

`default_nettype wire

//--- src/instDecoder.sv
// decode stage: opcode decode, ALU control, immediate and the decode/execute control register
`default_nettype none

`include "rvConsts.svh"

module instDecoder (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         icStall,
    input  rvPkg::instWord_t            ifInst,
    output logic                        exRegWrite,
    output logic                        exUseImm,
    output logic [3:0]                  exAluCtrl,
    output logic [`RV_XLEN-1:0]         exImm,
    output logic [`RV_REG_AW-1:0]       exRd,
    output logic [`RV_REG_AW-1:0]       exRs1,
    output logic [`RV_REG_AW-1:0]       exRs2
);

    logic                isOp;
    logic                isOpImm;
    logic                useF7;
    logic                ctrlLegal;
    logic                regWrite;
    logic [3:0]          aluCtrl;
    logic [`RV_XLEN-1:0] imm;

    // ============================================================
    // opcode and ALU control
    // ============================================================

    assign isOp    = (ifInst.rType.opcode == {`RV_OPC_OP, 2'b11});
    assign isOpImm = (ifInst.rType.opcode == {`RV_OPC_OPIMM, 2'b11});

    // immediate forms only look at bit 30 for SRAI
    assign useF7   = isOp || (ifInst.rType.funct3 == 3'b101);
    assign aluCtrl = {useF7 & ifInst.rType.funct7[5], ifInst.rType.funct3};

    always_comb begin
        case (aluCtrl)
            `RV_ALU_ADD, `RV_ALU_SUB, `RV_ALU_SLT,
            `RV_ALU_XOR, `RV_ALU_OR,  `RV_ALU_AND,
            `RV_ALU_SLL, `RV_ALU_SRL, `RV_ALU_SRA: ctrlLegal = 1'b1;
            default:                               ctrlLegal = 1'b0;
        endcase
    end

    // writes to x0 retire silently, so the reset NOP never reaches the trace
    assign regWrite = (isOp || isOpImm) && ctrlLegal && (ifInst.rType.rd != '0);

    // sign-extended I immediate
    assign imm = {{(`RV_XLEN - 12){ifInst.iType.imm12[11]}}, ifInst.iType.imm12};

    // ============================================================
    // decode/execute register
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exRegWrite <= 1'b0;
            exUseImm   <= 1'b0;
            exAluCtrl  <= `RV_ALU_ADD;
            exRd       <= '0;
            exRs1      <= '0;
            exRs2      <= '0;
        end else if (!icStall) begin
            exRegWrite <= regWrite;
            exUseImm   <= isOpImm;
            exAluCtrl  <= aluCtrl;
            exRd       <= ifInst.rType.rd;
            exRs1      <= ifInst.rType.rs1;
            exRs2      <= ifInst.rType.rs2;
        end
    end

    // immediate is payload
    always_ff @(posedge clk) begin
        if (!icStall) begin
            exImm <= imm;
        end
    end

endmodule

`default_nettype wire

//--- src/regFile.sv
// 32x32 register file with registered reads, write bypass and x0 tied to zero
`default_nettype none

`include "rvConsts.svh"

module regFile (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     icStall,
    input  wire  [`RV_REG_AW-1:0]   rs1,
    input  wire  [`RV_REG_AW-1:0]   rs2,
    input  wire                     wbValid,
    input  wire  [`RV_REG_AW-1:0]   wbRd,
    input  wire  [`RV_XLEN-1:0]     wbData,
    output logic [`RV_XLEN-1:0]     exOpA,
    output logic [`RV_XLEN-1:0]     exOpB
);

    // no storage behind x0
    logic [`RV_XLEN-1:0] regs [1:(1 << `RV_REG_AW) - 1];
    logic [`RV_XLEN-1:0] rdA;
    logic [`RV_XLEN-1:0] rdB;

    function automatic logic [`RV_XLEN-1:0] readReg(input logic [`RV_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        // same-cycle write wins over the stored value
        if (wbValid && (wbRd == addr)) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdA = readReg(rs1);
        rdB = readReg(rs2);
    end

    always_ff @(posedge clk) begin
        if (wbValid && (wbRd != '0)) begin
            regs[wbRd] <= wbData;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exOpA <= '0;
            exOpB <= '0;
        end else if (!icStall) begin
            exOpA <= rdA;
            exOpB <= rdB;
        end
    end

    x0ReadsZero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !icStall |=> (($past(rs1) != '0) || (exOpA == '0)) &&
                     (($past(rs2) != '0) || (exOpB == '0))
    ) else $error("registered read of x0 is nonzero");

endmodule

`default_nettype wire

//--- src/rvConsts.svh
// widths, opcodes, ALU control codes and fixed words for the RV32I core; include where needed
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ============================================================
// widths
// ============================================================
`define RV_XLEN     32
`define RV_REG_AW   5
`define RV_PC_W     30

// word-address step of the PC
`define RV_PC_STEP  30'd1

// ADDI x0,x0,0
`define RV_NOP      32'h0000_0013

// ============================================================
// major opcodes, instruction bits 6:2
// ============================================================
`define RV_OPC_OP     5'b01100
`define RV_OPC_OPIMM  5'b00100

// ============================================================
// ALU control, {funct7[5], funct3}
// ============================================================
`define RV_ALU_ADD  4'b0000
`define RV_ALU_SUB  4'b1000
`define RV_ALU_SLT  4'b0010
`define RV_ALU_XOR  4'b0100
`define RV_ALU_OR   4'b0110
`define RV_ALU_AND  4'b0111
`define RV_ALU_SLL  4'b0001
`define RV_ALU_SRL  4'b0101
`define RV_ALU_SRA  4'b1101

`endif

//--- src/rvCore.sv
// top level of the four-stage RV32I ALU core; instances and wires only
`default_nettype none

`include "rvConsts.svh"

module rvCore (
    input  wire                     clk,
    input  wire                     rst_n,
    output logic [`RV_PC_W-1:0]     icAddr,
    input  wire  [`RV_XLEN-1:0]     icRdata,
    input  wire                     icStall,
    output logic                    wbValid,
    output logic [`RV_REG_AW-1:0]   wbRd,
    output logic [`RV_XLEN-1:0]     wbData
);

    // fetch/decode
    rvPkg::instWord_t ifInst;

    // decode/execute
    logic                  exRegWrite;
    logic                  exUseImm;
    logic [3:0]            exAluCtrl;
    logic [`RV_XLEN-1:0]   exImm;
    logic [`RV_REG_AW-1:0] exRd;
    logic [`RV_REG_AW-1:0] exRs1;
    logic [`RV_REG_AW-1:0] exRs2;
    logic [`RV_XLEN-1:0]   exOpA;
    logic [`RV_XLEN-1:0]   exOpB;

    fetchUnit u_fetch (
        .clk(clk), .rst_n(rst_n), .icStall(icStall),
        .icRdata(icRdata), .icAddr(icAddr), .ifInst(ifInst)
    );

    // decoder and register file both work on the fetched word
    instDecoder u_decode (
        .clk(clk), .rst_n(rst_n), .icStall(icStall), .ifInst(ifInst),
        .exRegWrite(exRegWrite), .exUseImm(exUseImm), .exAluCtrl(exAluCtrl),
        .exImm(exImm), .exRd(exRd), .exRs1(exRs1), .exRs2(exRs2)
    );

    regFile u_regs (
        .clk(clk), .rst_n(rst_n), .icStall(icStall),
        .rs1(ifInst.rType.rs1), .rs2(ifInst.rType.rs2),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData),
        .exOpA(exOpA), .exOpB(exOpB)
    );

    executeStage u_exec (
        .clk(clk), .rst_n(rst_n), .icStall(icStall),
        .exRegWrite(exRegWrite), .exUseImm(exUseImm), .exAluCtrl(exAluCtrl),
        .exImm(exImm), .exOpA(exOpA), .exOpB(exOpB),
        .exRd(exRd), .exRs1(exRs1), .exRs2(exRs2),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

endmodule

`default_nettype wire

//--- src/rvPkg.sv
// shared types of the RV32I core; referenced by scoped name, never imported
`default_nettype none

`include "rvConsts.svh"

package rvPkg;

    // register-register view
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } instR_t;

    // register-immediate view
    typedef struct packed {
        logic [11:0]           imm12;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } instI_t;

    // one fetched word, two decodings
    typedef union packed {
        instR_t rType;
        instI_t iType;
    } instWord_t;

endpackage

`default_nettype wire

//--- vlog.f
+incdir+src
+incdir+sim
src/rvPkg.sv
src/fetchUnit.sv
src/instDecoder.sv
src/regFile.sv
src/executeStage.sv
src/rvCore.sv
sim/tbRvCore.sv
